/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_top
FILELIST := list.f
OBJ_DIR  := obj_dir
PASS_MSG := RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), fail unless the pass line appears"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_checks.svh */
// included inside tb_top after its signals; assumes falling-edge drive and a fixed one-cycle ack
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//////////////////////////////
// failure and compares
//////////////////////////////
task automatic report_fail(input string line);
  $display("%s", line);
  $display("RESULT: FAIL");
  $fatal(1, "stopped at first error");
endtask

task automatic check_word(input string name, input logic [BUS_W-1:0] got,
                          input logic [BUS_W-1:0] exp);
  if (got !== exp)
    report_fail($sformatf("FAIL %s got %h expected %h", name, got, exp));
endtask

task automatic check_raw(input string name, input raw_sample_t got, input raw_sample_t exp);
  if (got !== exp)
    report_fail($sformatf("FAIL %s got %h expected %h", name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp)
    report_fail($sformatf("FAIL %s got %h expected %h", name, got, exp));
endtask

// high cycles seen over one full period against the duty
task automatic check_pwm(input int ch, input logic [PWM_W-1:0] duty, input int high_cnt);
  if (high_cnt != int'(duty))
    report_fail($sformatf("FAIL dac_pwm_o[%0d] high count %h expected %h", ch, high_cnt, duty));
endtask

//////////////////////////////
// bus access
//////////////////////////////
function automatic logic [BUS_W-1:0] make_addr(input logic [REGION_W-1:0] region,
                                               input logic [OFFS_W-1:0] offs);
  return BUS_W'({region, offs});  // bits 31:23 left zero
endfunction

task automatic bus_write(input logic [BUS_W-1:0] addr, input logic [BUS_W-1:0] data,
                         input logic exp_err);
  @(negedge adc_clk);
  check_bit("sys_ack_o before strobe", sys_ack_o, 1'b0);  // no stray ack
  sys_addr_i  = addr;
  sys_wdata_i = data;
  sys_wen_i   = 1'b1;
  @(negedge adc_clk);
  check_bit("sys_ack_o", sys_ack_o, 1'b1);  // exactly one cycle later
  check_bit("sys_err_o", sys_err_o, exp_err);
  sys_wen_i = 1'b0;
endtask

task automatic bus_read(input logic [BUS_W-1:0] addr, input logic exp_err,
                        output logic [BUS_W-1:0] data);
  @(negedge adc_clk);
  check_bit("sys_ack_o before strobe", sys_ack_o, 1'b0);
  sys_addr_i = addr;
  sys_ren_i  = 1'b1;
  @(negedge adc_clk);
  check_bit("sys_ack_o", sys_ack_o, 1'b1);
  check_bit("sys_err_o", sys_err_o, exp_err);
  data      = sys_rdata_o;  // only valid in the ack cycle
  sys_ren_i = 1'b0;
endtask

// two read strobes on consecutive cycles, both answers checked in order
task automatic read_pair(input logic [BUS_W-1:0] addr0, input logic [BUS_W-1:0] exp0,
                         input logic [BUS_W-1:0] addr1, input logic [BUS_W-1:0] exp1);
  @(negedge adc_clk);
  sys_addr_i = addr0;
  sys_ren_i  = 1'b1;
  @(negedge adc_clk);
  check_bit("sys_ack_o first of pair", sys_ack_o, 1'b1);
  check_bit("sys_err_o first of pair", sys_err_o, 1'b0);
  check_word("sys_rdata_o first of pair", sys_rdata_o, exp0);
  sys_addr_i = addr1;  // strobe stays high
  @(negedge adc_clk);
  check_bit("sys_ack_o second of pair", sys_ack_o, 1'b1);
  check_bit("sys_err_o second of pair", sys_err_o, 1'b0);
  check_word("sys_rdata_o second of pair", sys_rdata_o, exp1);
  sys_ren_i = 1'b0;
endtask

`endif

/* dv/tb_top.sv */
// directed tests only; inputs change on the falling edge, outputs are sampled there too
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import rp_pkg::*;

  // cycle budget per test
  localparam int LEN_RESET  = 16;
  localparam int LEN_REGMAP = 100;
  localparam int LEN_EMPTY  = 150;
  localparam int LEN_PASS   = 200;
  localparam int LEN_ROUTER = 400;
  localparam int LEN_LOOP   = 300;
  localparam int LEN_PWM    = 600;
  localparam int TIMEOUT_CYCLES = 2 * (LEN_RESET + LEN_REGMAP + LEN_EMPTY + LEN_PASS +
                                       LEN_ROUTER + LEN_LOOP + LEN_PWM);

  logic               adc_clk;
  logic               rst_n_i;
  logic [BUS_W-1:0]   sys_addr_i;
  logic [BUS_W-1:0]   sys_wdata_i;
  logic               sys_wen_i;
  logic               sys_ren_i;
  logic [BUS_W-1:0]   sys_rdata_o;
  logic               sys_ack_o;
  logic               sys_err_o;
  raw_sample_t        adc_dat_a_i;
  raw_sample_t        adc_dat_b_i;
  raw_sample_t        dac_dat_a_o;
  raw_sample_t        dac_dat_b_o;
  logic [PWM_CH-1:0]  dac_pwm_o;
  logic [EXP_W-1:0]   led_o;
  logic [EXP_W-1:0]   exp_dat_i;
  logic [EXP_W-1:0]   exp_dat_o;
  logic [EXP_W-1:0]   exp_dir_o;

  logic [31:0]        lfsr_state = 32'h3b4517a5;
  int                 cycle_cnt  = 0;
  raw_sample_t        hist_a[$];  // last three adc pins, oldest first
  raw_sample_t        hist_b[$];

  rp_top rp_top_inst (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .dac_pwm_o   (dac_pwm_o),
    .led_o       (led_o),
    .exp_dat_i   (exp_dat_i),
    .exp_dat_o   (exp_dat_o),
    .exp_dir_o   (exp_dir_o)
  );

  `include "tb_checks.svh"

  initial
  begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;  // 20 ns period
  end

  always @(posedge adc_clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      report_fail($sformatf("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES));
  end

  //////////////////////////////
  // random source
  //////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;  // taps 32, 22, 2, 1
    else
      return s >> 1;
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v          = {v[30:0], lfsr_state[0]};  // bit shifted out
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // new random pin codes on both adc inputs
  task automatic drive_adc();
    logic [31:0] va;
    logic [31:0] vb;
    draw_bits(ADC_W, va);
    draw_bits(ADC_W, vb);
    adc_dat_a_i = va[ADC_W-1:0];
    adc_dat_b_i = vb[ADC_W-1:0];
    hist_a.push_back(adc_dat_a_i);
    hist_b.push_back(adc_dat_b_i);
    if (hist_a.size() > 3)
    begin
      void'(hist_a.pop_front());
      void'(hist_b.pop_front());
    end
  endtask

  // dac pins against the adc pins from three cycles back
  task automatic stream_check(input int n, input logic a_from_b);
    hist_a.delete();
    hist_b.delete();
    repeat (n)
    begin
      @(negedge adc_clk);
      if (hist_a.size() == 3)
      begin
        check_raw("dac_dat_a_o", dac_dat_a_o, a_from_b ? hist_b[0] : hist_a[0]);
        check_raw("dac_dat_b_o", dac_dat_b_o, hist_b[0]);
      end
      drive_adc();
    end
  endtask

  // channel a must hold one code while the adc inputs move
  task automatic hold_check(input int n, input raw_sample_t exp_a);
    repeat (2) @(negedge adc_clk);  // router then dac register
    repeat (n)
    begin
      @(negedge adc_clk);
      check_raw("dac_dat_a_o", dac_dat_a_o, exp_a);
      drive_adc();
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////
  task automatic register_map();
    logic [BUS_W-1:0] rd;
    logic [31:0]      v;
    bus_read(make_addr(REG_HK, HK_ID), 1'b0, rd);
    check_word("sys_rdata_o HK_ID", rd, HK_ID_VAL);
    draw_bits(32, v);
    bus_write(make_addr(REG_HK, HK_LED), v, 1'b0);
    check_word("led_o", BUS_W'(led_o), BUS_W'(v[EXP_W-1:0]));
    bus_read(make_addr(REG_HK, HK_LED), 1'b0, rd);
    check_word("sys_rdata_o HK_LED", rd, BUS_W'(v[EXP_W-1:0]));
    draw_bits(32, v);
    bus_write(make_addr(REG_HK, HK_EXP_DIR), v, 1'b0);
    check_word("exp_dir_o", BUS_W'(exp_dir_o), BUS_W'(v[EXP_W-1:0]));
    bus_read(make_addr(REG_HK, HK_EXP_DIR), 1'b0, rd);
    check_word("sys_rdata_o HK_EXP_DIR", rd, BUS_W'(v[EXP_W-1:0]));
    draw_bits(32, v);
    bus_write(make_addr(REG_HK, HK_EXP_OUT), v, 1'b0);
    check_word("exp_dat_o", BUS_W'(exp_dat_o), BUS_W'(v[EXP_W-1:0]));
    bus_read(make_addr(REG_HK, HK_EXP_OUT), 1'b0, rd);
    check_word("sys_rdata_o HK_EXP_OUT", rd, BUS_W'(v[EXP_W-1:0]));
    draw_bits(EXP_W, v);
    exp_dat_i = v[EXP_W-1:0];  // sampled before the read strobe
    bus_read(make_addr(REG_HK, HK_EXP_IN), 1'b0, rd);
    check_word("sys_rdata_o HK_EXP_IN", rd, BUS_W'(v[EXP_W-1:0]));
  endtask

  task automatic empty_and_unmapped();
    logic [REGION_W-1:0] empty_regions [5];
    logic [BUS_W-1:0]    rd;
    logic [31:0]         rnd;
    logic [EXP_W-1:0]    led_before;
    logic [EXP_W-1:0]    dir_before;
    logic [EXP_W-1:0]    out_before;
    empty_regions = '{3'd1, 3'd2, 3'd5, 3'd6, 3'd7};
    foreach (empty_regions[i])
    begin
      draw_bits(OFFS_W, rnd);
      bus_read(make_addr(empty_regions[i], rnd[OFFS_W-1:0]), 1'b0, rd);
      check_word("sys_rdata_o empty region", rd, '0);
    end
    draw_bits(32, rnd);
    bus_write(make_addr(3'd6, 20'h100), rnd, 1'b0);  // no slave, plain ack
    // hole in the housekeeping map
    led_before = led_o;
    dir_before = exp_dir_o;
    out_before = exp_dat_o;
    bus_write(make_addr(REG_HK, 20'h04), rnd, 1'b1);
    check_word("led_o after hole write", BUS_W'(led_o), BUS_W'(led_before));
    check_word("exp_dir_o after hole write", BUS_W'(exp_dir_o), BUS_W'(dir_before));
    check_word("exp_dat_o after hole write", BUS_W'(exp_dat_o), BUS_W'(out_before));
    bus_read(make_addr(REG_HK, 20'h04), 1'b1, rd);
    check_word("sys_rdata_o on err", rd, '0);
    bus_read(make_addr(REG_HK, 20'h24), 1'b1, rd);
    check_word("sys_rdata_o on err", rd, '0);
    bus_read(make_addr(REG_HK, HK_LED), 1'b0, rd);
    check_word("sys_rdata_o HK_LED", rd, BUS_W'(led_before));
    read_pair(make_addr(3'd5, 20'h0), '0, make_addr(REG_HK, HK_ID), HK_ID_VAL);
    read_pair(make_addr(REG_ROUTER, RT_SEL_B), BUS_W'(SRC_ADC_B),
              make_addr(REG_HK, HK_EXP_DIR), BUS_W'(dir_before));
  endtask

  task automatic router_selects();
    logic [BUS_W-1:0] rd;
    logic [31:0]      v;
    raw_sample_t      c;
    bus_write(make_addr(REG_ROUTER, RT_SEL_A), BUS_W'(SRC_ADC_B), 1'b0);
    bus_read(make_addr(REG_ROUTER, RT_SEL_A), 1'b0, rd);
    check_word("sys_rdata_o RT_SEL_A", rd, BUS_W'(SRC_ADC_B));
    stream_check(24, 1'b1);
    draw_bits(32, v);  // upper bits ignored by the register
    c = v[ADC_W-1:0];
    bus_write(make_addr(REG_ROUTER, RT_CONST_A), v, 1'b0);
    bus_read(make_addr(REG_ROUTER, RT_CONST_A), 1'b0, rd);
    check_word("sys_rdata_o RT_CONST_A", rd, {{(BUS_W-ADC_W){c[ADC_W-1]}}, c});
    bus_write(make_addr(REG_ROUTER, RT_SEL_A), BUS_W'(SRC_CONST), 1'b0);
    hold_check(12, {c[ADC_W-1], ~c[ADC_W-2:0]});  // lower bits flipped on the pin
    bus_write(make_addr(REG_ROUTER, RT_SEL_A), BUS_W'(SRC_ZERO), 1'b0);
    hold_check(12, {1'b0, {(ADC_W-1){1'b1}}});
    bus_write(make_addr(REG_ROUTER, RT_SEL_A), BUS_W'(SRC_ADC_A), 1'b0);
    stream_check(16, 1'b0);
  endtask

  task automatic digital_loop_hold();
    logic [BUS_W-1:0] rd;
    logic [31:0]      v;
    raw_sample_t      c;
    draw_bits(ADC_W, v);
    c = v[ADC_W-1:0];
    bus_write(make_addr(REG_ROUTER, RT_CONST_A), BUS_W'(c), 1'b0);
    bus_write(make_addr(REG_ROUTER, RT_SEL_A), BUS_W'(SRC_CONST), 1'b0);
    bus_write(make_addr(REG_HK, HK_DIGLOOP), 32'h1, 1'b0);
    bus_read(make_addr(REG_HK, HK_DIGLOOP), 1'b0, rd);
    check_word("sys_rdata_o HK_DIGLOOP", rd, 32'h1);
    bus_write(make_addr(REG_ROUTER, RT_SEL_A), BUS_W'(SRC_ADC_A), 1'b0);
    hold_check(32, {c[ADC_W-1], ~c[ADC_W-2:0]});  // router feeds itself
    bus_write(make_addr(REG_HK, HK_DIGLOOP), 32'h0, 1'b0);
    stream_check(16, 1'b0);  // back to the adc pins
  endtask

  task automatic pwm_duty_counts();
    logic [PWM_W-1:0]  duties [PWM_CH];
    logic [OFFS_W-1:0] offs [PWM_CH];
    int                high_cnt [PWM_CH];
    logic [BUS_W-1:0]  rd;
    duties = '{8'd0, 8'd64, 8'd200, 8'd255};
    offs   = '{PWM_DUTY0, PWM_DUTY1, PWM_DUTY2, PWM_DUTY3};
    for (int ch = 0; ch < PWM_CH; ch++)
    begin
      bus_write(make_addr(REG_PWM, offs[ch]), BUS_W'(duties[ch]), 1'b0);
      high_cnt[ch] = 0;
    end
    @(negedge adc_clk);  // last duty reaches its output
    repeat (256)
    begin
      @(negedge adc_clk);
      for (int ch = 0; ch < PWM_CH; ch++)
        high_cnt[ch] = high_cnt[ch] + (dac_pwm_o[ch] ? 1 : 0);
    end
    for (int ch = 0; ch < PWM_CH; ch++)
    begin
      check_pwm(ch, duties[ch], high_cnt[ch]);
      bus_read(make_addr(REG_PWM, offs[ch]), 1'b0, rd);
      check_word("sys_rdata_o PWM_DUTY", rd, BUS_W'(duties[ch]));
    end
  endtask

  //////////////////////////////
  // sequence
  //////////////////////////////
  initial
  begin
    rst_n_i     = 1'b0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    exp_dat_i   = '0;
    repeat (LEN_RESET) @(negedge adc_clk);
    rst_n_i = 1'b1;
    register_map();
    empty_and_unmapped();
    stream_check(64, 1'b0);  // reset defaults pass samples straight through
    router_selects();
    digital_loop_hold();
    pwm_duty_counts();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+dv
src/rp_pkg.sv
src/reg_bus_if.sv
src/sys_bus_decoder.sv
src/house_keeping.sv
src/analog_io.sv
src/output_router.sv
src/pwm_dac.sv
src/rp_top.sv
dv/tb_top.sv

/* src/analog_io.sv */
// pins use negative-slope offset code; adc capture has no reset, dac outputs clear on reset
`timescale 1ns/1ps
`default_nettype none

module analog_io (
  input  logic                adc_clk,
  input  logic                rst_n_i,
  input  rp_pkg::raw_sample_t adc_dat_a_i,
  input  rp_pkg::raw_sample_t adc_dat_b_i,
  input  logic                digital_loop_i,
  input  rp_pkg::sample_t     dac_a_i,
  input  rp_pkg::sample_t     dac_b_i,
  output rp_pkg::sample_t     adc_a_o,
  output rp_pkg::sample_t     adc_b_o,
  output rp_pkg::raw_sample_t dac_dat_a_o,
  output rp_pkg::raw_sample_t dac_dat_b_o
);
  import rp_pkg::*;

  raw_sample_t adc_a_q;  // pin capture, cycle 1
  raw_sample_t adc_b_q;

  // keep msb, invert the rest
  // same rule both ways so the two cancel
  function automatic raw_sample_t flip_code(input raw_sample_t code);
    return {code[ADC_W-1], ~code[ADC_W-2:0]};
  endfunction

  //////////////////////////////
  // adc side
  //////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    adc_a_q <= adc_dat_a_i;
    adc_b_q <= adc_dat_b_i;
  end

  // loop on: router output replaces the adc samples
  assign adc_a_o = digital_loop_i ? dac_a_i : sample_t'(flip_code(adc_a_q));
  assign adc_b_o = digital_loop_i ? dac_b_i : sample_t'(flip_code(adc_b_q));

  //////////////////////////////
  // dac side
  //////////////////////////////
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_dat_a_o <= '0;
      dac_dat_b_o <= '0;
    end
    else
    begin
      dac_dat_a_o <= flip_code(raw_sample_t'(dac_a_i));  // cycle 3 on the pin
      dac_dat_b_o <= flip_code(raw_sample_t'(dac_b_i));
    end
  end

endmodule

`default_nettype wire

/* src/house_keeping.sv */
// expansion input is sampled once, not synchronised; id and exp-in ignore writes silently
`timescale 1ns/1ps
`default_nettype none

module house_keeping (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  logic [rp_pkg::EXP_W-1:0] exp_dat_i,
  reg_bus_if.slave                 bus_i,
  output logic [rp_pkg::EXP_W-1:0] led_o,
  output logic [rp_pkg::EXP_W-1:0] exp_dat_o,
  output logic [rp_pkg::EXP_W-1:0] exp_dir_o,
  output logic                     digital_loop_o
);
  import rp_pkg::*;

  logic [EXP_W-1:0] exp_in_q;  // pin snapshot for readback
  logic [BUS_W-1:0] rd_val;
  logic             rd_hit;    // offset is mapped

  always_ff @(posedge adc_clk)
  begin
    exp_in_q <= exp_dat_i;
  end

  //////////////////////////////
  // register writes
  //////////////////////////////
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      led_o          <= '0;
      exp_dat_o      <= '0;
      exp_dir_o      <= '0;  // all pins input
      digital_loop_o <= 1'b0;
    end
    else if (bus_i.wen)
    begin
      case (bus_i.addr)
        HK_DIGLOOP: digital_loop_o <= bus_i.wdata[0];
        HK_EXP_DIR: exp_dir_o      <= bus_i.wdata[EXP_W-1:0];
        HK_EXP_OUT: exp_dat_o      <= bus_i.wdata[EXP_W-1:0];
        HK_LED:     led_o          <= bus_i.wdata[EXP_W-1:0];
        default:    ;  // id, exp-in and holes keep their value
      endcase
    end
  end

  // read mux and map check
  always_comb
  begin
    rd_hit = 1'b1;
    rd_val = '0;
    case (bus_i.addr)
      HK_ID:      rd_val = HK_ID_VAL;
      HK_DIGLOOP: rd_val = BUS_W'(digital_loop_o);
      HK_EXP_DIR: rd_val = BUS_W'(exp_dir_o);
      HK_EXP_OUT: rd_val = BUS_W'(exp_dat_o);
      HK_EXP_IN:  rd_val = BUS_W'(exp_in_q);
      HK_LED:     rd_val = BUS_W'(led_o);
      default:    rd_hit = 1'b0;
    endcase
  end

  // answer one cycle after the strobe
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      bus_i.ack   <= 1'b0;
      bus_i.err   <= 1'b0;
      bus_i.rdata <= '0;
    end
    else
    begin
      bus_i.ack   <= bus_i.wen | bus_i.ren;
      bus_i.err   <= (bus_i.wen | bus_i.ren) & ~rd_hit;
      bus_i.rdata <= (bus_i.ren & rd_hit) ? rd_val : '0;  // zero outside the ack cycle
    end
  end

endmodule

`default_nettype wire

/* src/output_router.sv */
// select takes only wdata[1:0], constants take the low ADC_W bits and read back sign-extended
`timescale 1ns/1ps
`default_nettype none

module output_router (
  input  logic            adc_clk,
  input  logic            rst_n_i,
  input  rp_pkg::sample_t adc_a_i,
  input  rp_pkg::sample_t adc_b_i,
  reg_bus_if.slave        bus_i,
  output rp_pkg::sample_t dac_a_o,
  output rp_pkg::sample_t dac_b_o
);
  import rp_pkg::*;

  rt_src_e          sel_a;
  rt_src_e          sel_b;
  sample_t          const_a;
  sample_t          const_b;
  logic [BUS_W-1:0] rd_val;
  logic             rd_hit;

  // source pick for one channel
  function automatic sample_t pick(input rt_src_e sel, input sample_t a,
                                   input sample_t b, input sample_t cst);
    case (sel)
      SRC_ADC_A: return a;
      SRC_ADC_B: return b;
      SRC_CONST: return cst;
      default:   return '0;  // SRC_ZERO
    endcase
  endfunction

  //////////////////////////////
  // config registers
  //////////////////////////////
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sel_a   <= RT_SEL_A_RST;
      sel_b   <= RT_SEL_B_RST;
      const_a <= '0;
      const_b <= '0;
    end
    else if (bus_i.wen)
    begin
      case (bus_i.addr)
        RT_SEL_A:   sel_a   <= rt_src_e'(bus_i.wdata[1:0]);
        RT_SEL_B:   sel_b   <= rt_src_e'(bus_i.wdata[1:0]);
        RT_CONST_A: const_a <= sample_t'(bus_i.wdata[ADC_W-1:0]);
        RT_CONST_B: const_b <= sample_t'(bus_i.wdata[ADC_W-1:0]);
        default:    ;
      endcase
    end
  end

  always_comb
  begin
    rd_hit = 1'b1;
    rd_val = '0;
    case (bus_i.addr)
      RT_SEL_A:   rd_val = BUS_W'(sel_a);
      RT_SEL_B:   rd_val = BUS_W'(sel_b);
      RT_CONST_A: rd_val = {{(BUS_W-ADC_W){const_a[ADC_W-1]}}, const_a};
      RT_CONST_B: rd_val = {{(BUS_W-ADC_W){const_b[ADC_W-1]}}, const_b};
      default:    rd_hit = 1'b0;
    endcase
  end

  // bus answer plus registered output mux, cycle 2 of the sample path
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      bus_i.ack   <= 1'b0;
      bus_i.err   <= 1'b0;
      bus_i.rdata <= '0;
      dac_a_o     <= '0;
      dac_b_o     <= '0;
    end
    else
    begin
      bus_i.ack   <= bus_i.wen | bus_i.ren;
      bus_i.err   <= (bus_i.wen | bus_i.ren) & ~rd_hit;
      bus_i.rdata <= (bus_i.ren & rd_hit) ? rd_val : '0;
      dac_a_o     <= pick(sel_a, adc_a_i, adc_b_i, const_a);
      dac_b_o     <= pick(sel_b, adc_a_i, adc_b_i, const_b);
    end
  end

endmodule

`default_nettype wire

/* src/pwm_dac.sv */
// 256-cycle period shared by all channels; duty 255 leaves one low cycle per period
`timescale 1ns/1ps
`default_nettype none

module pwm_dac (
  input  logic                      adc_clk,
  input  logic                      rst_n_i,
  reg_bus_if.slave                  bus_i,
  output logic [rp_pkg::PWM_CH-1:0] dac_pwm_o
);
  import rp_pkg::*;

  logic [PWM_W-1:0]          duty [PWM_CH];
  logic [PWM_W-1:0]          cnt;     // free running 0..255
  logic [$clog2(PWM_CH)-1:0] idx;     // duty register addressed
  logic                      idx_hit;

  // offset to channel
  always_comb
  begin
    idx_hit = 1'b1;
    idx     = '0;
    case (bus_i.addr)
      PWM_DUTY0: idx = 2'd0;
      PWM_DUTY1: idx = 2'd1;
      PWM_DUTY2: idx = 2'd2;
      PWM_DUTY3: idx = 2'd3;
      default:   idx_hit = 1'b0;
    endcase
  end

  //////////////////////////////
  // duty regs, bus answer, pwm
  //////////////////////////////
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < PWM_CH; i++)
        duty[i] <= '0;
      cnt         <= '0;
      dac_pwm_o   <= '0;
      bus_i.ack   <= 1'b0;
      bus_i.err   <= 1'b0;
      bus_i.rdata <= '0;
    end
    else
    begin
      if (bus_i.wen & idx_hit)
        duty[idx] <= bus_i.wdata[PWM_W-1:0];  // used from the next compare on
      cnt <= cnt + 1'b1;                      // wraps at 255
      for (int i = 0; i < PWM_CH; i++)
        dac_pwm_o[i] <= (cnt < duty[i]);      // high for duty counts per period
      bus_i.ack   <= bus_i.wen | bus_i.ren;
      bus_i.err   <= (bus_i.wen | bus_i.ren) & ~idx_hit;
      bus_i.rdata <= (bus_i.ren & idx_hit) ? BUS_W'(duty[idx]) : '0;
    end
  end

endmodule

`default_nettype wire

/* src/reg_bus_if.sv */
// one region of the host bus; strobes last one cycle, slave answers exactly one cycle later
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;
  import rp_pkg::*;

  //////////////////////////////
  // decoder side
  //////////////////////////////
  logic [OFFS_W-1:0] addr;   // in-region offset
  logic [BUS_W-1:0]  wdata;
  logic              wen;    // write strobe
  logic              ren;    // read strobe

  //////////////////////////////
  // slave side
  //////////////////////////////
  logic [BUS_W-1:0]  rdata;  // valid with ack only
  logic              ack;
  logic              err;    // unmapped offset

  modport host  (output addr, wdata, wen, ren, input  rdata, ack, err);
  modport slave (input  addr, wdata, wen, ren, output rdata, ack, err);

endinterface

`default_nettype wire

/* src/rp_pkg.sv */
// single adc_clk domain, full-word access only, region field fixed at addr[22:20]
package rp_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////
  localparam int ADC_W    = 14;  // adc and dac sample
  localparam int BUS_W    = 32;  // bus data and address
  localparam int REGION_W = 3;   // region select, sits right above the offset
  localparam int OFFS_W   = 20;  // offset inside one region
  localparam int PWM_W    = 8;   // duty and counter
  localparam int PWM_CH   = 4;
  localparam int EXP_W    = 8;   // single-ended expansion port

  // region map, codes 1, 2, 5, 6, 7 have no slave
  typedef enum logic [REGION_W-1:0] {
    REG_HK     = 3'd0,
    REG_ROUTER = 3'd3,
    REG_PWM    = 3'd4
  } region_e;

  // housekeeping offsets
  localparam logic [OFFS_W-1:0] HK_ID      = 20'h00;
  localparam logic [OFFS_W-1:0] HK_DIGLOOP = 20'h0C;  // bit 0 only
  localparam logic [OFFS_W-1:0] HK_EXP_DIR = 20'h10;  // 1 = drive pin
  localparam logic [OFFS_W-1:0] HK_EXP_OUT = 20'h18;
  localparam logic [OFFS_W-1:0] HK_EXP_IN  = 20'h20;  // read only
  localparam logic [OFFS_W-1:0] HK_LED     = 20'h30;

  localparam logic [BUS_W-1:0] HK_ID_VAL = 32'h5250_0A01;  // board id word

  // router offsets
  localparam logic [OFFS_W-1:0] RT_SEL_A   = 20'h00;
  localparam logic [OFFS_W-1:0] RT_SEL_B   = 20'h04;
  localparam logic [OFFS_W-1:0] RT_CONST_A = 20'h08;
  localparam logic [OFFS_W-1:0] RT_CONST_B = 20'h0C;

  // pwm duty offsets
  localparam logic [OFFS_W-1:0] PWM_DUTY0 = 20'h00;
  localparam logic [OFFS_W-1:0] PWM_DUTY1 = 20'h04;
  localparam logic [OFFS_W-1:0] PWM_DUTY2 = 20'h08;
  localparam logic [OFFS_W-1:0] PWM_DUTY3 = 20'h0C;

  // router source per dac channel
  typedef enum logic [1:0] {
    SRC_ADC_A = 2'd0,
    SRC_ADC_B = 2'd1,
    SRC_CONST = 2'd2,
    SRC_ZERO  = 2'd3
  } rt_src_e;

  localparam rt_src_e RT_SEL_A_RST = SRC_ADC_A;  // straight through after reset
  localparam rt_src_e RT_SEL_B_RST = SRC_ADC_B;

  typedef logic signed [ADC_W-1:0] sample_t;      // two's complement
  typedef logic        [ADC_W-1:0] raw_sample_t;  // pin code, negative slope

endpackage

/* src/rp_top.sv */
// one clock for bus, samples and pwm; expansion tristate buffers live outside this core
`timescale 1ns/1ps
`default_nettype none

module rp_top (
  input  logic                      adc_clk,
  input  logic                      rst_n_i,
  // host bus
  input  logic [rp_pkg::BUS_W-1:0]  sys_addr_i,
  input  logic [rp_pkg::BUS_W-1:0]  sys_wdata_i,
  input  logic                      sys_wen_i,
  input  logic                      sys_ren_i,
  output logic [rp_pkg::BUS_W-1:0]  sys_rdata_o,
  output logic                      sys_ack_o,
  output logic                      sys_err_o,
  // fast analog
  input  rp_pkg::raw_sample_t       adc_dat_a_i,
  input  rp_pkg::raw_sample_t       adc_dat_b_i,
  output rp_pkg::raw_sample_t       dac_dat_a_o,
  output rp_pkg::raw_sample_t       dac_dat_b_o,
  // slow outputs and expansion
  output logic [rp_pkg::PWM_CH-1:0] dac_pwm_o,
  output logic [rp_pkg::EXP_W-1:0]  led_o,
  input  logic [rp_pkg::EXP_W-1:0]  exp_dat_i,
  output logic [rp_pkg::EXP_W-1:0]  exp_dat_o,
  output logic [rp_pkg::EXP_W-1:0]  exp_dir_o
);
  import rp_pkg::*;

  logic    digital_loop;  // hk -> analog
  sample_t adc_a;         // analog -> router
  sample_t adc_b;
  sample_t dac_a;         // router -> analog
  sample_t dac_b;

  //////////////////////////////
  // register bus
  //////////////////////////////
  reg_bus_if hk_bus  ();  // region 0
  reg_bus_if rt_bus  ();  // region 3
  reg_bus_if pwm_bus ();  // region 4

  sys_bus_decoder sys_bus_decoder_inst (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .hk_o        (hk_bus.host),
    .rt_o        (rt_bus.host),
    .pwm_o       (pwm_bus.host)
  );

  house_keeping house_keeping_inst (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .exp_dat_i      (exp_dat_i),
    .bus_i          (hk_bus.slave),
    .led_o          (led_o),
    .exp_dat_o      (exp_dat_o),
    .exp_dir_o      (exp_dir_o),
    .digital_loop_o (digital_loop)
  );

  //////////////////////////////
  // sample path
  //////////////////////////////
  analog_io analog_io_inst (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dac_a_i        (dac_a),
    .dac_b_i        (dac_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b),
    .dac_dat_a_o    (dac_dat_a_o),
    .dac_dat_b_o    (dac_dat_b_o)
  );

  output_router output_router_inst (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .adc_a_i (adc_a),
    .adc_b_i (adc_b),
    .bus_i   (rt_bus.slave),
    .dac_a_o (dac_a),
    .dac_b_o (dac_b)
  );

  pwm_dac pwm_dac_inst (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .bus_i     (pwm_bus.slave),
    .dac_pwm_o (dac_pwm_o)
  );

endmodule

`default_nettype wire

/* src/sys_bus_decoder.sv */
// no back-pressure; two accesses may be in flight, responses return in strobe order
`timescale 1ns/1ps
`default_nettype none

module sys_bus_decoder (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  logic [rp_pkg::BUS_W-1:0] sys_addr_i,
  input  logic [rp_pkg::BUS_W-1:0] sys_wdata_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  output logic [rp_pkg::BUS_W-1:0] sys_rdata_o,
  output logic                     sys_ack_o,
  output logic                     sys_err_o,
  reg_bus_if.host                  hk_o,
  reg_bus_if.host                  rt_o,
  reg_bus_if.host                  pwm_o
);
  import rp_pkg::*;

  region_e region;        // region of the current strobe
  region_e region_q;      // region whose answer is due now
  logic    strobe;
  logic    unused_hit;
  logic    unused_ack_q;  // local answer for empty regions

  assign region     = region_e'(sys_addr_i[OFFS_W +: REGION_W]);
  assign strobe     = sys_wen_i | sys_ren_i;
  assign unused_hit = !(region inside {REG_HK, REG_ROUTER, REG_PWM});

  //////////////////////////////
  // request fan-out
  //////////////////////////////
  assign hk_o.addr   = sys_addr_i[OFFS_W-1:0];
  assign hk_o.wdata  = sys_wdata_i;
  assign hk_o.wen    = sys_wen_i & (region == REG_HK);  // strobe only to addressed region
  assign hk_o.ren    = sys_ren_i & (region == REG_HK);
  assign rt_o.addr   = sys_addr_i[OFFS_W-1:0];
  assign rt_o.wdata  = sys_wdata_i;
  assign rt_o.wen    = sys_wen_i & (region == REG_ROUTER);
  assign rt_o.ren    = sys_ren_i & (region == REG_ROUTER);
  assign pwm_o.addr  = sys_addr_i[OFFS_W-1:0];
  assign pwm_o.wdata = sys_wdata_i;
  assign pwm_o.wen   = sys_wen_i & (region == REG_PWM);
  assign pwm_o.ren   = sys_ren_i & (region == REG_PWM);

  // remember who was asked, answer comes next cycle
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      region_q     <= REG_HK;
      unused_ack_q <= 1'b0;
    end
    else
    begin
      if (strobe)
        region_q <= region;
      unused_ack_q <= strobe & unused_hit;  // zero data, no err
    end
  end

  //////////////////////////////
  // response return
  //////////////////////////////
  always_comb
  begin
    case (region_q)
      REG_HK:     {sys_rdata_o, sys_ack_o, sys_err_o} = {hk_o.rdata, hk_o.ack, hk_o.err};
      REG_ROUTER: {sys_rdata_o, sys_ack_o, sys_err_o} = {rt_o.rdata, rt_o.ack, rt_o.err};
      REG_PWM:    {sys_rdata_o, sys_ack_o, sys_err_o} = {pwm_o.rdata, pwm_o.ack, pwm_o.err};
      default:    {sys_rdata_o, sys_ack_o, sys_err_o} = {{BUS_W{1'b0}}, unused_ack_q, 1'b0};
    endcase
  end

endmodule

`default_nettype wire
